//--- Bender.yml
package:
  name: pshpul

sources:
  - src/pshpul_pkg.sv
  - src/pshpul_step_if.sv
  - src/pshpul_seq.sv
  - src/pshpul_pick.sv
  - src/pshpul_xfer.sv
  - src/pshpul_regs.sv
  - src/pshpul_ram.sv
  - src/pshpul_unit.sv
  - target: test
    files:
      - tests/pshpul_tb.sv

//--- sources.f
src/pshpul_pkg.sv
src/pshpul_step_if.sv
src/pshpul_seq.sv
src/pshpul_pick.sv
src/pshpul_xfer.sv
src/pshpul_regs.sv
src/pshpul_ram.sv
src/pshpul_unit.sv
tests/pshpul_tb.sv

//--- src/pshpul_pick.sv
// Priority picker.
// Highest set mask bit for push, lowest for pull, as one-hot.

`timescale 1ns/1ps

module pshpul_pick (
    pshpul_step_if.pick step
);

    logic [7:0] lo_bit;
    logic [7:0] hi_bit;

    // Lowest set bit, two's complement trick.
    assign lo_bit = step.psh_sel & (~step.psh_sel + 8'h01);

    // ******************************************************************
    // Highest set bit
    // ******************************************************************
    // Ascending scan, the last hit is the top bit.
    always_comb begin
        hi_bit = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (step.psh_sel[i]) begin
                hi_bit = 8'h01 << i;
            end
        end
    end

    // Push goes PC first, pull goes CC first.
    // Empty mask gives zero either way.
    assign step.psh_bit = step.dec_us ? hi_bit : lo_bit;

endmodule

//--- src/pshpul_pkg.sv
// Shared definitions for the stack push/pull unit.
// Register identifiers, postbyte bit positions, condition-code flag index
// and the fixed interrupt postbytes.

package pshpul_pkg;

    // Register file identifiers. Entries from REG_X upward are 16 bits.
    typedef enum logic [3:0] {
        REG_CC = 4'd0,
        REG_A  = 4'd1,
        REG_B  = 4'd2,
        REG_DP = 4'd3,
        REG_X  = 4'd4,
        REG_Y  = 4'd5,
        REG_U  = 4'd6,
        REG_S  = 4'd7,
        REG_PC = 4'd8
    } reg_id_t;

    // Postbyte bit positions. Bits 7 to 4 select 16-bit registers.
    localparam int PB_CC    = 0;
    localparam int PB_A     = 1;
    localparam int PB_B     = 2;
    localparam int PB_DP    = 3;
    localparam int PB_X     = 4;
    localparam int PB_Y     = 5;
    localparam int PB_OTHER = 6;    // The stack pointer not in use.
    localparam int PB_PC    = 7;

    localparam int CC_E = 7;        // Entire-state flag.

    // Interrupt entry masks.
    localparam logic [7:0] INT_ALL  = 8'hFF;
    localparam logic [7:0] INT_FAST = 8'((1 << PB_PC) | (1 << PB_CC));

endpackage

//--- src/pshpul_ram.sv
// Byte-wide stack RAM.
// Asynchronous read, synchronous write, 2**AW bytes.

`timescale 1ns/1ps

module pshpul_ram #(
    parameter int unsigned AW = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] addr,
    input  logic [7:0]    wdata,
    output logic [7:0]    rdata
);

    logic [7:0] mem [2**AW];   // Contents undefined at power-up.

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];   // Combinational read.

endmodule

//--- src/pshpul_regs.sv
// CPU register file.
// Nine registers with a load and read port, a stack-byte port selected
// by postbyte bit, and the active stack pointer port.

`timescale 1ns/1ps

module pshpul_regs (
    input  logic                clk,
    input  logic                rst,

    input  logic                ld_en,
    input  pshpul_pkg::reg_id_t ld_id,
    input  logic [15:0]         ld_data,
    input  pshpul_pkg::reg_id_t rd_id,
    output logic [15:0]         rd_data,

    input  logic [7:0]          psh_bit,
    input  logic                us_sel,
    output logic [15:0]         stk_word,
    input  logic                byte_we,
    input  logic                byte_hi,
    input  logic [7:0]          byte_data,

    output logic [15:0]         ptr,
    input  logic                ptr_we,
    input  logic [15:0]         ptr_next
);

    logic [15:0]         regs [9];   // 8-bit registers keep upper byte zero.
    pshpul_pkg::reg_id_t stk_id;
    pshpul_pkg::reg_id_t ptr_id;

    // Postbyte bit to register. PB_OTHER is the stack not in use.
    always_comb begin
        stk_id = pshpul_pkg::REG_CC;
        case (1'b1)
            psh_bit[pshpul_pkg::PB_A]:     stk_id = pshpul_pkg::REG_A;
            psh_bit[pshpul_pkg::PB_B]:     stk_id = pshpul_pkg::REG_B;
            psh_bit[pshpul_pkg::PB_DP]:    stk_id = pshpul_pkg::REG_DP;
            psh_bit[pshpul_pkg::PB_X]:     stk_id = pshpul_pkg::REG_X;
            psh_bit[pshpul_pkg::PB_Y]:     stk_id = pshpul_pkg::REG_Y;
            psh_bit[pshpul_pkg::PB_OTHER]: stk_id = us_sel ? pshpul_pkg::REG_S
                                                           : pshpul_pkg::REG_U;
            psh_bit[pshpul_pkg::PB_PC]:    stk_id = pshpul_pkg::REG_PC;
            default:                       stk_id = pshpul_pkg::REG_CC;
        endcase
    end

    assign ptr_id   = us_sel ? pshpul_pkg::REG_U : pshpul_pkg::REG_S;
    assign stk_word = regs[stk_id];
    assign ptr      = regs[ptr_id];
    assign rd_data  = regs[rd_id];

    // Stack writes after loads, so they win.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 9; i++) begin
                regs[i] <= 16'h0000;
            end
        end else begin
            if (ld_en) begin
                regs[ld_id] <= (ld_id >= pshpul_pkg::REG_X) ? ld_data
                                                             : {8'h00, ld_data[7:0]};
            end
            if (byte_we) begin
                if (byte_hi) begin
                    regs[stk_id][15:8] <= byte_data;
                end else begin
                    regs[stk_id][7:0] <= byte_data;
                end
            end
            if (ptr_we) begin
                regs[ptr_id] <= ptr_next;   // Pointer move.
            end
        end
    end

endmodule

//--- src/pshpul_seq.sv
// Postbyte sequencer.
// Latches the register mask on a go strobe and retires one register
// per step, holding two steps for 16-bit registers.

`timescale 1ns/1ps

module pshpul_seq (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,

    input  logic [7:0]  op,
    input  logic [7:0]  postdata,
    input  logic [7:0]  cc,
    input  logic        int_en,

    input  logic        psh_go,
    input  logic        pul_go,
    output logic        busy,

    pshpul_step_if.seq  step
);

    logic [7:0] postbyte;
    logic       wide;

    // Interrupt entry overrides the instruction postbyte.
    assign postbyte = int_en ? (cc[pshpul_pkg::CC_E] ? pshpul_pkg::INT_ALL
                                                     : pshpul_pkg::INT_FAST)
                             : postdata;

    assign busy = step.psh_sel != 8'h00;   // Any register left.
    assign wide = step.psh_bit[pshpul_pkg::PB_PC:pshpul_pkg::PB_X] != 4'h0;

    // ******************************************************************
    // Mask and phase state
    // ******************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step.psh_sel <= 8'h00;
            step.hi_lon  <= 1'b0;
            step.dec_us  <= 1'b0;
            step.us_sel  <= 1'b0;
        end else if (cen) begin
            if (!busy) begin
                // Go strobes are only honoured while idle.
                if (psh_go || pul_go) begin
                    step.psh_sel <= postbyte;
                    step.us_sel  <= op[0];
                    step.hi_lon  <= 1'b1;
                    step.dec_us  <= psh_go;   // Push wins a tie.
                end
            end else if (wide && step.hi_lon) begin
                step.hi_lon <= 1'b0;          // Second byte still due.
            end else begin
                // Last byte of this register.
                step.hi_lon  <= 1'b1;
                step.psh_sel <= step.psh_sel & ~step.psh_bit;
            end
        end
    end

endmodule

//--- src/pshpul_step_if.sv
// Step bundle between sequencer, picker and transfer stage.
// Active mask, picked bit, byte phase, direction and stack choice.

`timescale 1ns/1ps

interface pshpul_step_if;

    logic [7:0] psh_sel;    // Registers still to move.
    logic [7:0] psh_bit;    // One-hot, register of this step.
    logic       hi_lon;     // First byte of a 16-bit register.
    logic       dec_us;     // High for push.
    logic       us_sel;     // Pointer is U when high.

    // Sequencer owns the mask and phase.
    modport seq (output psh_sel, output hi_lon, output dec_us, output us_sel,
                 input  psh_bit);

    // Picker turns the mask into one bit.
    modport pick (input psh_sel, input dec_us, output psh_bit);

    // Transfer stage only observes.
    modport xfer (input psh_bit, input hi_lon, input dec_us, input us_sel);

endinterface

//--- src/pshpul_unit.sv
// Push/pull unit top level.
// Connects sequencer, picker, transfer stage, register file and RAM.

`timescale 1ns/1ps

module pshpul_unit #(
    parameter int unsigned AW = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,

    input  logic [7:0]          op,
    input  logic [7:0]          postdata,
    input  logic [7:0]          cc,
    input  logic                int_en,
    input  logic                psh_go,
    input  logic                pul_go,
    output logic                busy,

    input  logic                ld_en,
    input  pshpul_pkg::reg_id_t ld_id,
    input  logic [15:0]         ld_data,
    input  pshpul_pkg::reg_id_t rd_id,
    output logic [15:0]         rd_data
);

    logic [15:0]   stk_word;
    logic [15:0]   ptr;
    logic          ptr_we;
    logic [15:0]   ptr_next;
    logic          byte_we;
    logic          byte_hi;
    logic [7:0]    byte_data;
    logic [AW-1:0] ram_addr;
    logic          ram_we;
    logic [7:0]    ram_wdata;
    logic [7:0]    ram_rdata;

    pshpul_step_if step ();

    // ******************************************************************
    // Stage chain
    // ******************************************************************
    pshpul_seq u_seq (
        .clk(clk), .rst(rst), .cen(cen),
        .op(op), .postdata(postdata), .cc(cc), .int_en(int_en),
        .psh_go(psh_go), .pul_go(pul_go), .busy(busy),
        .step(step.seq)
    );

    pshpul_pick u_pick (
        .step(step.pick)
    );

    pshpul_xfer #(.AW(AW)) u_xfer (
        .clk(clk), .rst(rst), .cen(cen),
        .step(step.xfer),
        .stk_word(stk_word), .ptr(ptr), .ptr_we(ptr_we), .ptr_next(ptr_next),
        .byte_we(byte_we), .byte_hi(byte_hi), .byte_data(byte_data),
        .ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

    // ******************************************************************
    // Storage
    // ******************************************************************
    pshpul_regs u_regs (
        .clk(clk), .rst(rst),
        .ld_en(ld_en), .ld_id(ld_id), .ld_data(ld_data),
        .rd_id(rd_id), .rd_data(rd_data),
        .psh_bit(step.psh_bit), .us_sel(step.us_sel), .stk_word(stk_word),
        .byte_we(byte_we), .byte_hi(byte_hi), .byte_data(byte_data),
        .ptr(ptr), .ptr_we(ptr_we), .ptr_next(ptr_next)
    );

    pshpul_ram #(.AW(AW)) u_ram (
        .clk(clk), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

//--- src/pshpul_xfer.sv
// Transfer stage.
// Moves one byte per step between register file and stack RAM,
// and writes back the moved stack pointer.

`timescale 1ns/1ps

module pshpul_xfer #(
    parameter int unsigned AW = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,

    pshpul_step_if.xfer   step,

    // Register file side.
    input  logic [15:0]   stk_word,
    input  logic [15:0]   ptr,
    output logic          ptr_we,
    output logic [15:0]   ptr_next,
    output logic          byte_we,
    output logic          byte_hi,
    output logic [7:0]    byte_data,

    // RAM side.
    output logic [AW-1:0] ram_addr,
    output logic          ram_we,
    output logic [7:0]    ram_wdata,
    input  logic [7:0]    ram_rdata
);

    logic          active;
    logic          wide;
    logic          push_step;
    logic [15:0]   ptr_dec;
    logic [7:0]    push_byte;
    logic          wr_q;
    logic [AW-1:0] waddr_q;
    logic [7:0]    wdata_q;

    assign active    = cen && (step.psh_bit != 8'h00);
    assign wide      = step.psh_bit[pshpul_pkg::PB_PC:pshpul_pkg::PB_X] != 4'h0;
    assign push_step = active && step.dec_us;
    assign ptr_dec   = ptr - 16'd1;

    // ******************************************************************
    // Pointer and register byte
    // ******************************************************************
    assign ptr_we   = active;
    assign ptr_next = step.dec_us ? ptr_dec : ptr + 16'd1;   // Post-increment on pull.

    assign byte_we   = active && !step.dec_us;
    assign byte_hi   = wide && step.hi_lon;   // Pull takes high byte first.
    assign byte_data = ram_rdata;

    // Push stores low byte first, so words land big-endian.
    assign push_byte = (wide && !step.hi_lon) ? stk_word[15:8] : stk_word[7:0];

    // ******************************************************************
    // Registered RAM write port
    // ******************************************************************
    // Write lands on the next enabled edge after the step.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_q <= 1'b0;
        end else if (cen) begin
            wr_q <= push_step;
        end
    end

    always_ff @(posedge clk) begin
        if (push_step) begin
            waddr_q <= ptr_dec[AW-1:0];   // Pre-decrement address.
            wdata_q <= push_byte;
        end
    end

    assign ram_we    = wr_q && cen;   // Held over a stall.
    assign ram_wdata = wdata_q;
    assign ram_addr  = wr_q ? waddr_q : ptr[AW-1:0];   // Pull reads at pointer.

endmodule

//--- tests/pshpul_tb.sv
// Self-checking testbench for the push/pull unit.
// LCG register values and masks, immediate and concurrent assertions,
// cycle watchdog.

`timescale 1ns/1ps

module pshpul_tb;

    localparam int unsigned AW   = 8;
    localparam logic [31:0] SEED = 32'd84936;
    localparam int NUM_OPS   = 25;   // Pushes and pulls below.
    localparam int NUM_LOADS = 152;
    localparam int NUM_READS = 136;
    // Thirteen cycles per op tripled for stalls plus loads and reads.
    localparam int CYCLE_LIMIT = NUM_OPS * 13 * 3 + NUM_LOADS * 2 + NUM_READS + 300;

    logic                clk;
    logic                rst;
    logic                cen;
    logic [7:0]          op;
    logic [7:0]          postdata;
    logic [7:0]          cc;
    logic                int_en;
    logic                psh_go;
    logic                pul_go;
    logic                busy;
    logic                ld_en;
    pshpul_pkg::reg_id_t ld_id;
    logic [15:0]         ld_data;
    pshpul_pkg::reg_id_t rd_id;
    logic [15:0]         rd_data;

    logic [31:0] rand_state;
    logic [31:0] cen_state;
    logic        cen_random;       // Stall mode.
    int          busy_cycles;      // Enabled edges with busy high.
    int          cycles;
    int          checks;
    int          errors;
    logic [15:0] expect_val [9];   // Register file model.
    logic [15:0] pushed_val [9];   // Snapshot at push time.

    pshpul_unit #(.AW(AW)) DUT (
        .clk(clk), .rst(rst), .cen(cen),
        .op(op), .postdata(postdata), .cc(cc), .int_en(int_en),
        .psh_go(psh_go), .pul_go(pul_go), .busy(busy),
        .ld_en(ld_en), .ld_id(ld_id), .ld_data(ld_data),
        .rd_id(rd_id), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ******************************************************************
    // Model helpers
    // ******************************************************************
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] next_rand();
        rand_state = lcg_step(rand_state);
        return rand_state[31:16];   // Upper half of the state.
    endfunction

    // One byte per 8-bit register and two per word register.
    function automatic int byte_count(input logic [7:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) n += (i >= pshpul_pkg::PB_X) ? 2 : 1;
        end
        return n;
    endfunction

    // Register selected by the mask. PB_OTHER is the idle stack.
    function automatic logic in_mask(input logic [7:0] mask, input int id, input logic us);
        case (id)
            pshpul_pkg::REG_CC: return mask[pshpul_pkg::PB_CC];
            pshpul_pkg::REG_A:  return mask[pshpul_pkg::PB_A];
            pshpul_pkg::REG_B:  return mask[pshpul_pkg::PB_B];
            pshpul_pkg::REG_DP: return mask[pshpul_pkg::PB_DP];
            pshpul_pkg::REG_X:  return mask[pshpul_pkg::PB_X];
            pshpul_pkg::REG_Y:  return mask[pshpul_pkg::PB_Y];
            pshpul_pkg::REG_U:  return !us && mask[pshpul_pkg::PB_OTHER];
            pshpul_pkg::REG_S:  return us && mask[pshpul_pkg::PB_OTHER];
            default:            return mask[pshpul_pkg::PB_PC];
        endcase
    endfunction

    function automatic logic [15:0] trim_to_reg(input int id, input logic [15:0] v);
        return (id >= pshpul_pkg::REG_X) ? v : {8'h00, v[7:0]};   // Byte regs.
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ******************************************************************
    // Port drivers on the falling edge
    // ******************************************************************
    task automatic load_reg(input int id, input logic [15:0] v);
        @(negedge clk);
        ld_en          = 1'b1;
        ld_id          = pshpul_pkg::reg_id_t'(id);
        ld_data        = v;
        expect_val[id] = trim_to_reg(id, v);
        @(negedge clk);
        ld_en = 1'b0;
    endtask

    task automatic check_reg(input string name, input int id);
        @(negedge clk);
        rd_id = pshpul_pkg::reg_id_t'(id);
        #10;                                     // Settled read path.
        check_value(name, expect_val[id], rd_data);
    endtask

    task automatic check_all(input string name);
        for (int i = 0; i < 9; i++) check_reg(name, i);
    endtask

    // Go is held until taken and optionally through busy.
    task automatic run_op(input string name, input logic push, input logic [7:0] mask,
                          input logic us, input logic irq, input logic [7:0] cc_val,
                          input logic hold_go, input int n_exp);
        @(negedge clk);
        op          = {7'b0, us};
        postdata    = mask;
        cc          = cc_val;
        int_en      = irq;
        psh_go      = push;
        pul_go      = !push;
        busy_cycles = 0;
        @(negedge clk);
        while (!busy) @(negedge clk);   // Waits out low cen.
        if (!hold_go) begin
            psh_go = 1'b0;
            pul_go = 1'b0;
        end
        while (busy) @(negedge clk);
        psh_go = 1'b0;
        pul_go = 1'b0;
        int_en = 1'b0;
        check_value({name, " busy length"}, 16'(n_exp), 16'(busy_cycles));
    endtask

    task automatic round_trip(input string name, input logic hold_go);
        logic [15:0] r;
        logic [7:0]  mask;
        int          n;
        for (int i = 0; i < 9; i++) load_reg(i, next_rand());
        r    = next_rand();
        mask = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
        n    = byte_count(mask);
        run_op(name, 1'b1, mask, 1'b0, 1'b0, 8'h00, hold_go, n);
        expect_val[pshpul_pkg::REG_S] -= 16'(n);   // Pointer drop.
        check_reg({name, " push S"}, pshpul_pkg::REG_S);
        for (int i = 0; i < 9; i++) pushed_val[i] = expect_val[i];
        for (int i = 0; i < 9; i++) begin
            if (i != pshpul_pkg::REG_S) load_reg(i, next_rand());
        end
        run_op(name, 1'b0, mask, 1'b0, 1'b0, 8'h00, 1'b0, n);
        for (int i = 0; i < 9; i++) begin
            if (in_mask(mask, i, 1'b0)) expect_val[i] = pushed_val[i];
        end
        expect_val[pshpul_pkg::REG_S] += 16'(n);
        check_all(name);
    endtask

    // ******************************************************************
    // Clock enable, watchdog and busy counter
    // ******************************************************************
    always @(negedge clk) begin
        if (cen_random) begin
            cen_state = lcg_step(cen_state);
            cen = cen_state[20];
        end else begin
            cen = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (busy && cen) busy_cycles++;   // One byte moved.
    end

    // A go taken while idle with a non-empty mask raises busy on the next edge.
    assert property (@(posedge clk) disable iff (rst)
        (cen && !busy && (psh_go || pul_go) && (int_en || postdata != 8'h00)) |=> busy)
    else begin
        errors++;
        $display("busy did not rise on the edge after an accepted go strobe");
    end

    // A low cen freezes an operation in progress.
    assert property (@(posedge clk) disable iff (rst) (busy && !cen) |=> busy)
    else begin
        errors++;
        $display("busy dropped on an edge with cen low");
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, an operation never finished", cycles);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [15:0] keep;
        logic [15:0] r;
        logic [31:0] trip_seed;
        rst = 1'b1;
        cen = 1'b1;
        op = 8'h00;
        postdata = 8'h00;
        cc = 8'h00;
        int_en = 1'b0;
        psh_go = 1'b0;
        pul_go = 1'b0;
        ld_en = 1'b0;
        ld_id = pshpul_pkg::REG_CC;
        ld_data = 16'h0000;
        rd_id = pshpul_pkg::REG_CC;
        rand_state = SEED;
        cen_state = SEED;
        cen_random = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 9; i++) expect_val[i] = 16'h0000;
        check_all("reset");

        // Round trips replayed with the same values under stalls.
        for (int k = 0; k < 4; k++) begin
            trip_seed  = rand_state;
            cen_random = 1'b0;
            round_trip("round trip", k[0]);
            rand_state = trip_seed;
            cen_random = 1'b1;
            round_trip("stall trip", 1'b0);
        end
        cen_random = 1'b0;

        // X lands big-endian so A gets the high byte.
        load_reg(pshpul_pkg::REG_X, next_rand());
        run_op("byte order", 1'b1, 8'h01 << pshpul_pkg::PB_X, 1'b0, 1'b0, 8'h00, 1'b0, 2);
        run_op("byte order", 1'b0, 8'h06, 1'b0, 1'b0, 8'h00, 1'b0, 2);
        expect_val[pshpul_pkg::REG_A] = {8'h00, expect_val[pshpul_pkg::REG_X][15:8]};
        expect_val[pshpul_pkg::REG_B] = {8'h00, expect_val[pshpul_pkg::REG_X][7:0]};
        check_all("byte order");
        load_reg(pshpul_pkg::REG_A, next_rand());
        run_op("byte copy", 1'b1, 8'h01 << pshpul_pkg::PB_A, 1'b0, 1'b0, 8'h00, 1'b0, 1);
        run_op("byte copy", 1'b0, 8'h01 << pshpul_pkg::PB_B, 1'b0, 1'b0, 8'h00, 1'b0, 1);
        expect_val[pshpul_pkg::REG_B] = expect_val[pshpul_pkg::REG_A];
        check_all("byte copy");

        // S saved on the U stack.
        load_reg(pshpul_pkg::REG_S, next_rand());
        load_reg(pshpul_pkg::REG_U, next_rand());
        keep = expect_val[pshpul_pkg::REG_S];
        run_op("u stack", 1'b1, 8'h01 << pshpul_pkg::PB_OTHER, 1'b1, 1'b0, 8'h00, 1'b0, 2);
        expect_val[pshpul_pkg::REG_U] -= 16'd2;
        check_all("u stack push");
        load_reg(pshpul_pkg::REG_S, next_rand());
        run_op("u stack", 1'b0, 8'h01 << pshpul_pkg::PB_OTHER, 1'b1, 1'b0, 8'h00, 1'b0, 2);
        expect_val[pshpul_pkg::REG_U] += 16'd2;
        expect_val[pshpul_pkg::REG_S] = keep;
        check_all("u stack pull");

        // Interrupt entry with the full mask and then the fast one.
        for (int i = 0; i < 9; i++) load_reg(i, next_rand());
        r = next_rand();
        run_op("irq entire", 1'b1, 8'h00, 1'b0, 1'b1, r[7:0] | 8'h80, 1'b0, 12);
        expect_val[pshpul_pkg::REG_S] -= 16'd12;
        check_reg("irq entire S", pshpul_pkg::REG_S);
        run_op("irq fast", 1'b1, 8'h00, 1'b0, 1'b1, r[15:8] & 8'h7F, 1'b0, 3);
        expect_val[pshpul_pkg::REG_S] -= 16'd3;
        check_reg("irq fast S", pshpul_pkg::REG_S);
        for (int i = 0; i < 9; i++) pushed_val[i] = expect_val[i];
        load_reg(pshpul_pkg::REG_PC, next_rand());
        load_reg(pshpul_pkg::REG_CC, next_rand());
        run_op("irq return", 1'b0, 8'h00, 1'b0, 1'b1, 8'h00, 1'b0, 3);
        expect_val[pshpul_pkg::REG_PC] = pushed_val[pshpul_pkg::REG_PC];
        expect_val[pshpul_pkg::REG_CC] = pushed_val[pshpul_pkg::REG_CC];
        expect_val[pshpul_pkg::REG_S] += 16'd3;
        check_all("irq return");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
